//--- common/tile_macros.svh
`ifndef TILE_MACROS_SVH
`define TILE_MACROS_SVH

// Data width of one flit payload.
`define TILE_DATA_W 16

// Number of entries in the configuration store.
`define TILE_CFG_DEPTH 16

// Width of a configuration address.
`define TILE_PC_W 4

// Neighbor directions N, E, S, W.
`define TILE_NUM_DIRS 4

// Width of a source or route code.
`define TILE_SRC_W 3

`endif

//--- common/tile_pkg.sv
`default_nettype none

`include "tile_macros.svh"

package tile_pkg;

	typedef logic [`TILE_DATA_W-1:0] data_t;
	typedef logic [`TILE_PC_W-1:0] pc_t;
	typedef logic [`TILE_SRC_W-1:0] src_t;
	typedef logic [`TILE_SRC_W-1:0] route_t;

	typedef struct packed {
		logic  valid;
		data_t data;
	} flit_t;

	// Source codes 0 to 3 select neighbors N, E, S, W.
	localparam src_t SRC_TREG = 3'd4;
	localparam src_t SRC_NONE = 3'd7;

	// Route codes 0 to 3 pass the captured neighbor input through.
	localparam route_t ROUTE_ALU = 3'd4;
	localparam route_t ROUTE_TREG = 3'd5;
	localparam route_t ROUTE_NONE = 3'd7;

	typedef enum logic [3:0] {
		op_nop,
		op_add,
		op_sub,
		op_mul,
		op_and,
		op_or,
		op_xor,
		op_shl,
		op_shr,
		op_sel,
		op_lt,
		op_set_loop
	} opcode_t;

	typedef struct packed {
		opcode_t                         opcode;
		src_t                            src_a;
		src_t                            src_b;
		src_t                            src_p;
		logic                            pred_inv;
		logic                            use_imm;
		logic                            treg_we;
		route_t [`TILE_NUM_DIRS-1:0]     route;
		data_t                           imm;
	} cfg_word_t;

	typedef struct packed {
		pc_t       addr;
		cfg_word_t word;
	} cfg_write_t;

	typedef struct packed {
		cfg_word_t                   word;
		flit_t                       a;
		flit_t                       b;
		flit_t                       p;
		flit_t [`TILE_NUM_DIRS-1:0]  flit_in;
	} operand_t;

	typedef struct packed {
		logic valid;
		pc_t  start;
		pc_t  end_;
	} loop_update_t;

endpackage

`default_nettype wire

//--- logic/tile_alu.sv
`default_nettype none

module tile_alu import tile_pkg::*; (
	input  opcode_t i_op,
	input  data_t   i_a,
	input  data_t   i_b,
	output data_t   o_result
);

	logic [3:0] shamt;

	// Shift amount is b modulo 16.
	assign shamt = i_b[3:0];

	always_comb begin
		case (i_op)
			op_add: begin
				o_result = i_a + i_b;
			end
			op_sub: begin
				o_result = i_a - i_b;
			end
			op_mul: begin
				o_result = i_a * i_b;
			end
			op_and: begin
				o_result = i_a & i_b;
			end
			op_or: begin
				o_result = i_a | i_b;
			end
			op_xor: begin
				o_result = i_a ^ i_b;
			end
			op_shl: begin
				o_result = i_a << shamt;
			end
			op_shr: begin
				o_result = i_a >> shamt;
			end
			op_sel: begin
				o_result = i_a;
			end
			op_lt: begin
				o_result = data_t'(i_a < i_b);
			end
			default: begin
				o_result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- fetch/fetch_stage.sv
`default_nettype none

`include "tile_macros.svh"

module fetch_stage import tile_pkg::*; (
	input  logic         clk,
	input  logic         reset,
	input  logic         i_run,
	input  logic         i_cfg_req,
	input  cfg_write_t   i_cfg,
	output logic         o_cfg_ack,
	input  loop_update_t i_loop,
	output cfg_word_t    o_word,
	output logic         o_word_valid
);

	cfg_word_t cfg_mem [`TILE_CFG_DEPTH];
	pc_t pc;
	pc_t loop_start;
	pc_t loop_end;
	pc_t wrap_start;
	pc_t wrap_end;
	logic cfg_write;

	// Write on the first edge of a new request.
	assign cfg_write = i_cfg_req && !o_cfg_ack;

	always_ff @(posedge clk) begin
		if (reset) begin
			o_cfg_ack <= 1'b0;
		end else if (cfg_write) begin
			o_cfg_ack <= 1'b1;
		end else if (!i_cfg_req) begin
			o_cfg_ack <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (cfg_write) begin
			cfg_mem[i_cfg.addr] <= i_cfg.word;
		end
	end

	// New bounds from execute already govern the wrap on this edge.
	assign wrap_start = i_loop.valid ? i_loop.start : loop_start;
	assign wrap_end = i_loop.valid ? i_loop.end_ : loop_end;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			loop_start <= '0;
			loop_end <= pc_t'(`TILE_CFG_DEPTH - 1);
			o_word_valid <= 1'b0;
		end else if (i_run) begin
			if (pc == wrap_end) begin
				pc <= wrap_start;
			end else begin
				pc <= pc_t'(pc + 1'b1);
			end
			if (i_loop.valid) begin
				loop_start <= i_loop.start;
				loop_end <= i_loop.end_;
			end
			o_word_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_run) begin
			o_word <= cfg_mem[pc];
		end
	end

endmodule

`default_nettype wire

//--- logic/operand_stage.sv
`default_nettype none

`include "tile_macros.svh"

module operand_stage import tile_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       i_run,
	input  cfg_word_t                  i_word,
	input  logic                       i_word_valid,
	input  flit_t [`TILE_NUM_DIRS-1:0] i_flit_in,
	input  flit_t                      i_treg,
	output operand_t                   o_opnd,
	output logic                       o_opnd_valid
);

	flit_t flit_a;
	flit_t flit_b;
	flit_t flit_p;

	// Unused or unknown codes give an invalid flit with zero data.
	function automatic flit_t pick_source(
		input src_t                       src,
		input flit_t [`TILE_NUM_DIRS-1:0] flits,
		input flit_t                      treg
	);
		flit_t sel;
		sel = '0;
		if (src < src_t'(`TILE_NUM_DIRS)) begin
			sel = flits[src[1:0]];
		end else if (src == SRC_TREG) begin
			sel = treg;
		end
		return sel;
	endfunction

	always_comb begin
		flit_a = pick_source(i_word.src_a, i_flit_in, i_treg);
		flit_p = pick_source(i_word.src_p, i_flit_in, i_treg);
		if (i_word.use_imm) begin
			flit_b.valid = 1'b1;
			flit_b.data = data_t'(i_word.imm);
		end else begin
			flit_b = pick_source(i_word.src_b, i_flit_in, i_treg);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			o_opnd_valid <= 1'b0;
		end else if (i_run) begin
			o_opnd_valid <= i_word_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (i_run) begin
			o_opnd.word <= i_word;
			o_opnd.a <= flit_a;
			o_opnd.b <= flit_b;
			o_opnd.p <= flit_p;
			o_opnd.flit_in <= i_flit_in;
		end
	end

endmodule

`default_nettype wire

//--- execute/execute_stage.sv
`default_nettype none

`include "tile_macros.svh"

module execute_stage import tile_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       i_run,
	input  operand_t                   i_opnd,
	input  logic                       i_opnd_valid,
	input  data_t                      i_result,
	output opcode_t                    o_alu_op,
	output data_t                      o_alu_a,
	output data_t                      o_alu_b,
	output flit_t                      o_treg,
	output loop_update_t               o_loop,
	output flit_t [`TILE_NUM_DIRS-1:0] o_flit_out
);

	cfg_word_t word;
	logic pred_pass;
	logic a_ok;
	logic b_ok;
	logic fire;
	flit_t res_flit;

	assign word = i_opnd.word;

	// Select falls back to b when a is missing.
	assign o_alu_op = word.opcode;
	assign o_alu_a = (word.opcode == op_sel && !i_opnd.a.valid) ? i_opnd.b.data : i_opnd.a.data;
	assign o_alu_b = i_opnd.b.data;

	assign pred_pass = (word.src_p == SRC_NONE) ||
		(i_opnd.p.valid && ((i_opnd.p.data != '0) ^ word.pred_inv));
	assign a_ok = (word.src_a == SRC_NONE) || i_opnd.a.valid;
	assign b_ok = (word.src_b == SRC_NONE && !word.use_imm) || i_opnd.b.valid;

	always_comb begin
		case (word.opcode)
			op_nop, op_set_loop: begin
				fire = 1'b0;
			end
			op_sel: begin
				fire = pred_pass && (i_opnd.a.valid || i_opnd.b.valid);
			end
			default: begin
				fire = pred_pass && a_ok && b_ok;
			end
		endcase
	end

	assign res_flit.valid = i_opnd_valid && fire;
	assign res_flit.data = res_flit.valid ? i_result : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			o_treg <= '0;
			o_loop <= '0;
			o_flit_out <= '0;
		end else if (i_run) begin
			if (i_opnd_valid && word.treg_we) begin
				o_treg <= res_flit;
			end
			// Bounds pulse lasts one run edge.
			o_loop.valid <= i_opnd_valid && word.opcode == op_set_loop;
			o_loop.start <= word.imm[3:0];
			o_loop.end_ <= word.imm[7:4];
			for (int d = 0; d < `TILE_NUM_DIRS; d++) begin
				if (!i_opnd_valid) begin
					o_flit_out[d] <= '0;
				end else if (word.route[d] < route_t'(`TILE_NUM_DIRS)) begin
					o_flit_out[d] <= i_opnd.flit_in[word.route[d][1:0]];
				end else if (word.route[d] == ROUTE_ALU) begin
					o_flit_out[d] <= res_flit;
				end else if (word.route[d] == ROUTE_TREG) begin
					o_flit_out[d] <= o_treg;
				end else begin
					o_flit_out[d] <= '0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/tile_top.sv
`default_nettype none

`include "tile_macros.svh"

module tile_top import tile_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       i_run,
	input  logic                       i_cfg_req,
	input  cfg_write_t                 i_cfg,
	output logic                       o_cfg_ack,
	input  flit_t [`TILE_NUM_DIRS-1:0] i_flit_in,
	output flit_t [`TILE_NUM_DIRS-1:0] o_flit_out
);

	cfg_word_t word;
	logic word_valid;
	operand_t opnd;
	logic opnd_valid;
	flit_t treg;
	loop_update_t loop_upd;
	opcode_t alu_op;
	data_t alu_a;
	data_t alu_b;
	data_t alu_result;

	fetch_stage u_fetch (
		.clk          (clk),
		.reset        (reset),
		.i_run        (i_run),
		.i_cfg_req    (i_cfg_req),
		.i_cfg        (i_cfg),
		.o_cfg_ack    (o_cfg_ack),
		.i_loop       (loop_upd),
		.o_word       (word),
		.o_word_valid (word_valid)
	);

	operand_stage u_operand (
		.clk          (clk),
		.reset        (reset),
		.i_run        (i_run),
		.i_word       (word),
		.i_word_valid (word_valid),
		.i_flit_in    (i_flit_in),
		.i_treg       (treg),
		.o_opnd       (opnd),
		.o_opnd_valid (opnd_valid)
	);

	tile_alu u_alu (
		.i_op     (alu_op),
		.i_a      (alu_a),
		.i_b      (alu_b),
		.o_result (alu_result)
	);

	execute_stage u_execute (
		.clk          (clk),
		.reset        (reset),
		.i_run        (i_run),
		.i_opnd       (opnd),
		.i_opnd_valid (opnd_valid),
		.i_result     (alu_result),
		.o_alu_op     (alu_op),
		.o_alu_a      (alu_a),
		.o_alu_b      (alu_b),
		.o_treg       (treg),
		.o_loop       (loop_upd),
		.o_flit_out   (o_flit_out)
	);

endmodule

`default_nettype wire

//--- bench/tile_tb.sv
`default_nettype none

`include "tile_macros.svh"

module tile_tb import tile_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_LIMIT = 32;

	logic                       clk;
	logic                       reset;
	logic                       i_run;
	logic                       i_cfg_req;
	cfg_write_t                 i_cfg;
	logic                       o_cfg_ack;
	flit_t [`TILE_NUM_DIRS-1:0] i_flit_in;
	flit_t [`TILE_NUM_DIRS-1:0] o_flit_out;

	// Expected output sets, each with the run edge after which it is due.
	flit_t [`TILE_NUM_DIRS-1:0] exp_q[$];
	int due_q[$];
	int run_count;

	// Outputs the tile should still show while it is stalled.
	flit_t [`TILE_NUM_DIRS-1:0] last_exp;

	tile_top dut (
		.clk        (clk),
		.reset      (reset),
		.i_run      (i_run),
		.i_cfg_req  (i_cfg_req),
		.i_cfg      (i_cfg),
		.o_cfg_ack  (o_cfg_ack),
		.i_flit_in  (i_flit_in),
		.o_flit_out (o_flit_out)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_flit(input string name, input flit_t got, input flit_t exp);
		if (got.valid !== exp.valid || (exp.valid && got.data !== exp.data)) begin
			stop_with_error($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_ack(input logic got, input logic exp);
		if (got !== exp) begin
			stop_with_error($sformatf("FAILED o_cfg_ack: got 0x%h, expected 0x%h", got, exp));
		end
	endtask

	task automatic compare_outputs(input flit_t [`TILE_NUM_DIRS-1:0] expv);
		last_exp = expv;
		for (int d = 0; d < `TILE_NUM_DIRS; d++) begin
			check_flit($sformatf("o_flit_out[%0d]", d), o_flit_out[d], expv[d]);
		end
	endtask

	// Four-phase write into the configuration store.
	task automatic write_cfg(input pc_t addr, input cfg_word_t word);
		int cnt;
		@(posedge clk);
		i_cfg_req <= 1'b1;
		i_cfg.addr <= addr;
		i_cfg.word <= word;
		// Ack may only rise on an edge that has seen the request.
		@(negedge clk);
		check_ack(o_cfg_ack, 1'b0);
		cnt = 0;
		while (o_cfg_ack !== 1'b1 && cnt < WAIT_LIMIT) begin
			@(negedge clk);
			cnt++;
		end
		if (o_cfg_ack !== 1'b1) begin
			stop_with_error("Timeout: the configuration write was never acknowledged.");
		end
		@(posedge clk);
		i_cfg_req <= 1'b0;
		// Ack holds until an edge has seen the request low.
		@(negedge clk);
		check_ack(o_cfg_ack, 1'b1);
		cnt = 0;
		while (o_cfg_ack !== 1'b0 && cnt < WAIT_LIMIT) begin
			@(negedge clk);
			cnt++;
		end
		if (o_cfg_ack !== 1'b0) begin
			stop_with_error("Timeout: acknowledge stayed high after the request dropped.");
		end
	endtask

	// One clock: drive on the rising edge, check due results on the falling edge.
	task automatic run_cycle(input logic run, input flit_t [`TILE_NUM_DIRS-1:0] flits,
			input logic push, input flit_t [`TILE_NUM_DIRS-1:0] expv);
		@(posedge clk);
		if (i_run) begin
			run_count++;
		end
		i_run <= run;
		i_flit_in <= flits;
		if (push) begin
			exp_q.push_back(expv);
			due_q.push_back(run_count + 2);
		end
		@(negedge clk);
		if (due_q.size() > 0 && due_q[0] == run_count) begin
			compare_outputs(exp_q.pop_front());
			void'(due_q.pop_front());
		end
	endtask

	// The first cycle still closes the last run edge, the rest must hold its result.
	task automatic hold_stall(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			run_cycle(1'b0, '0, 1'b0, '0);
			if (i > 0) begin
				compare_outputs(last_exp);
			end
		end
	endtask

	initial begin
		int fd;
		int n;
		int cycles;
		int cnt;
		string line;
		pc_t addr;
		logic [$bits(cfg_word_t)-1:0] word;
		logic [$bits(flit_t)-1:0] col [2*`TILE_NUM_DIRS];
		flit_t [`TILE_NUM_DIRS-1:0] flits;
		flit_t [`TILE_NUM_DIRS-1:0] expv;

		reset <= 1'b1;
		i_run <= 1'b0;
		i_cfg_req <= 1'b0;
		i_cfg <= '0;
		i_flit_in <= '0;
		run_count = 0;
		repeat (3) begin
			@(posedge clk);
		end
		reset <= 1'b0;
		@(negedge clk);
		check_ack(o_cfg_ack, 1'b0);
		compare_outputs('0);

		fd = $fopen("bench/tile_golden.txt", "r");
		if (fd == 0) begin
			stop_with_error("Could not open the golden file.");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			case (line[0])
				"C": begin
					n = $sscanf(line, "C %h %h", addr, word);
					if (n != 2) begin
						stop_with_error({"Malformed configuration line: ", line});
					end
					write_cfg(addr, cfg_word_t'(word));
				end
				"S": begin
					n = $sscanf(line, "S %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
						col[3], col[4], col[5], col[6], col[7]);
					if (n != 2 * `TILE_NUM_DIRS) begin
						stop_with_error({"Malformed step line: ", line});
					end
					for (int d = 0; d < `TILE_NUM_DIRS; d++) begin
						flits[d] = col[d];
						expv[d] = col[d + `TILE_NUM_DIRS];
					end
					run_cycle(1'b1, flits, 1'b1, expv);
				end
				"W": begin
					n = $sscanf(line, "W %d", cycles);
					if (n != 1) begin
						stop_with_error({"Malformed stall line: ", line});
					end
					hold_stall(cycles);
				end
				default: begin
					stop_with_error({"Unknown line in the golden file: ", line});
				end
			endcase
		end
		$fclose(fd);

		// Run on until the last steps have reached the outputs.
		cnt = 0;
		while (exp_q.size() > 0 && cnt < WAIT_LIMIT) begin
			run_cycle(1'b1, '0, 1'b0, '0);
			cnt++;
		end
		if (exp_q.size() > 0) begin
			stop_with_error("Timeout: expected outputs never came due.");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- bench/tile_golden.txt
# C addr word : configuration write, word is cfg_word_t in 11 hex digits
# S n e s w out0 out1 out2 out3 : input flits, then outputs due two run edges later
# W cycles : cycles with i_run low; flits are valid bit and 16-bit data in 5 hex digits
C 0 1078fd40000
C 1 30b873f0000
C 2 71fa9f90003
C 3 1050ffc0000
C 4 a054ffc0000
C 5 9078ffc0000
C 6 11fbffc0100
C 7 19fafec0001
C 8 2838ffc0000
C 9 bff8fc400ca
C a 6078ffc0000
C b 5078fe70000
C c 81faf3f0014
S 00000 00000 00000 00000 00000 00000 00000 00000
S 10005 10003 1abcd 00000 10008 1abcd 00000 00000
S 10123 00000 10100 17777 00000 00000 12300 17777
S 18421 100ee 00000 00000 100ee 00000 00000 12108
S 10010 10020 10000 00000 00000 00000 00000 00000
W 3
S 18000 17fff 10000 00000 10000 00000 00000 00000
S 01111 12222 00000 00000 12222 00000 00000 00000
S 10034 00000 00000 00000 10134 00000 00000 00000
S 10999 00000 00000 00000 00000 10134 00000 00000
S 10004 00000 00000 00000 10130 00000 00000 00000
S 15a5a 00000 00000 00000 00000 15a5a 00000 00000
S 100ff 10f0f 00000 00000 10ff0 00000 00000 00000
S 11200 10034 00000 00000 00000 11234 00000 00000
S 1abcd 00000 00000 00000 00000 00000 10abc 00000
S 11234 05678 00000 00000 00000 00000 00000 00000
S 1000f 100f0 00000 00000 00000 100ff 00000 00000
S 1ffff 00000 00000 00000 00000 00000 10fff 00000
S 1aaaa 15555 00000 00000 1ffff 00000 00000 00000

//--- flist.f
+incdir+common
common/tile_pkg.sv
logic/tile_alu.sv
fetch/fetch_stage.sv
logic/operand_stage.sv
execute/execute_stage.sv
logic/tile_top.sv
bench/tile_tb.sv

//--- Bender.yml
package:
  name: tile

sources:
  - include_dirs:
      - common
    files:
      - common/tile_pkg.sv
      - logic/tile_alu.sv
      - fetch/fetch_stage.sv
      - logic/operand_stage.sv
      - execute/execute_stage.sv
      - logic/tile_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/tile_tb.sv
